// File: hyp_config.svh
`ifndef HYP_CONFIG_SVH
`define HYP_CONFIG_SVH

// Datapath widths for the vector magnitude pipeline

// Operand width, one tile input byte each
`define HYP_IN_W 8

// Square of one operand
`define HYP_SQ_W 16

// Sum of both squares, full width with carry
`define HYP_SUM_W 17

// Root of the 17-bit radicand, max 360
`define HYP_ROOT_W 9

// Saturated result on uo_out
`define HYP_OUT_W 8

`endif

// File: hyp_pkg.sv
`include "hyp_config.svh"

package hyp_pkg;

    // One unsigned input operand
    typedef logic [`HYP_IN_W-1:0] operand_t;

    // Product of an operand with itself
    typedef logic [`HYP_SQ_W-1:0] square_t;

    // Radicand, x*x + y*y without carry loss
    typedef logic [`HYP_SUM_W-1:0] sumsq_t;

    // Partial root while stepping, final floor root at the end
    typedef logic [`HYP_ROOT_W-1:0] root_t;

    // Output byte after saturation
    typedef logic [`HYP_OUT_W-1:0] pix_t;

endpackage

// File: hyp_square_stage.sv
`timescale 1ns/100ps

module hyp_square_stage (
    input  logic              clk,      // Tile clock
    input  logic              rst_n,    // Async reset, active low
    input  logic              ena,      // Pipeline advance
    input  hyp_pkg::operand_t x,        // From ui_in
    input  hyp_pkg::operand_t y,        // From uio_in
    output hyp_pkg::square_t  square_x, // Registered x*x
    output hyp_pkg::square_t  square_y  // Registered y*y
);

    import hyp_pkg::*;

    square_t prod_x; // Combinational x*x
    square_t prod_y; // Combinational y*y

    // 8x8 unsigned product fits 16 bits exactly
    always_comb begin
        prod_x = square_t'(x) * square_t'(x);
        prod_y = square_t'(y) * square_t'(y);
    end

    // Stage 1 registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            square_x <= '0; // Root of zero is zero
            square_y <= '0;
        end else if (ena) begin
            square_x <= prod_x; // Sample on enabled edge only
            square_y <= prod_y;
        end
    end

endmodule

// File: hyp_sum_stage.sv
`timescale 1ns/100ps

module hyp_sum_stage (
    input  logic             clk,      // Tile clock
    input  logic             rst_n,    // Async reset, active low
    input  logic             ena,      // Pipeline advance
    input  hyp_pkg::square_t square_x, // From stage 1
    input  hyp_pkg::square_t square_y, // From stage 1
    output hyp_pkg::sumsq_t  sum_sq    // Radicand for the root pipe
);

    import hyp_pkg::*;

    sumsq_t sum_next; // Full-width sum before the register

    // Zero-extend both squares so the carry lands in bit 16
    always_comb begin
        sum_next = sumsq_t'(square_x) + sumsq_t'(square_y);
    end

    // Stage 2 register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_sq <= '0;
        end else if (ena) begin
            sum_sq <= sum_next; // Max 130050
        end
    end

endmodule

// File: hyp_root_step.sv
`timescale 1ns/100ps
`include "hyp_config.svh"

module hyp_root_step #(
    parameter int BIT_POS = 0 // Root bit decided here, 8 down to 0
) (
    input  logic            clk,      // Tile clock
    input  logic            rst_n,    // Async reset, active low
    input  logic            ena,      // Pipeline advance
    input  hyp_pkg::sumsq_t rad_in,   // Radicand of this pair
    input  hyp_pkg::root_t  root_in,  // Bits above BIT_POS already final
    output hyp_pkg::sumsq_t rad_out,  // Radicand, delayed with the root
    output hyp_pkg::root_t  root_out  // Root with BIT_POS decided
);

    import hyp_pkg::*;

    localparam int PROD_W = 2 * `HYP_ROOT_W; // Square of a 9-bit trial root

    root_t             trial_root; // root_in with BIT_POS set
    logic [PROD_W-1:0] trial_sq;   // trial_root squared, no overflow
    logic              keep_bit;   // Trial fits under the radicand
    root_t             root_next;  // Root after this step

    // Trial root, lower bits still zero
    always_comb begin
        trial_root = root_in | (root_t'(1) << BIT_POS);
    end

    // Exact square at 18 bits
    always_comb begin
        trial_sq = PROD_W'(trial_root) * PROD_W'(trial_root);
    end

    // Restoring decision
    // Keep the bit only while trial^2 <= radicand, so the root stays a floor
    always_comb begin
        keep_bit = (trial_sq <= PROD_W'(rad_in));
        if (keep_bit) begin
            root_next = trial_root;
        end else begin
            root_next = root_in; // Bit stays clear
        end
    end

    // Step register
    // Radicand travels alongside so every pair in flight keeps its own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rad_out  <= '0;
            root_out <= '0;
        end else if (ena) begin
            rad_out  <= rad_in;    // Unchanged, just delayed
            root_out <= root_next; // One more bit settled
        end
    end

endmodule

// File: hyp_root_pipe.sv
`timescale 1ns/100ps
`include "hyp_config.svh"

module hyp_root_pipe (
    input  logic            clk,       // Tile clock
    input  logic            rst_n,     // Async reset, active low
    input  logic            ena,       // Pipeline advance
    input  hyp_pkg::sumsq_t sum_sq,    // Radicand from the sum stage
    output hyp_pkg::pix_t   magnitude  // Saturated floor root
);

    import hyp_pkg::*;

    localparam int STEPS = `HYP_ROOT_W; // One step per root bit
    localparam int MSB   = `HYP_ROOT_W - 1; // Bit 8, set only above 255

    // Chain taps; index k feeds step k
    sumsq_t rad_chain  [0:STEPS-1]; // Radicands into each step
    root_t  root_chain [0:STEPS];   // Partial roots, last entry is final

    pix_t   sat_next; // Saturated value before the output register

    // Chain head
    assign rad_chain[0]  = sum_sq;
    assign root_chain[0] = '0; // No bits decided yet

    // Nine steps, MSB first
    // Step k decides bit STEPS-1-k
    genvar k;
    generate
        for (k = 0; k < STEPS; k++) begin : g_step
            if (k < STEPS - 1) begin : g_mid
                hyp_root_step #(
                    .BIT_POS (STEPS - 1 - k)
                ) u_step (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .ena      (ena),
                    .rad_in   (rad_chain[k]),
                    .root_in  (root_chain[k]),
                    .rad_out  (rad_chain[k+1]),  // Next step's radicand
                    .root_out (root_chain[k+1])
                );
            end else begin : g_last
                hyp_root_step #(
                    .BIT_POS (STEPS - 1 - k)     // Bit 0
                ) u_step (
                    .clk      (clk),
                    .rst_n    (rst_n),
                    .ena      (ena),
                    .rad_in   (rad_chain[k]),
                    .root_in  (root_chain[k]),
                    .rad_out  (),                // Radicand not needed past bit 0
                    .root_out (root_chain[k+1])  // Final floor root
                );
            end
        end
    endgenerate

    // Saturation
    // Any root above 255 has bit 8 set, so that bit alone decides
    always_comb begin
        if (root_chain[STEPS][MSB]) begin
            sat_next = '1; // Clamp to 255
        end else begin
            sat_next = root_chain[STEPS][`HYP_OUT_W-1:0];
        end
    end

    // Output register, the tenth stage of this block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            magnitude <= '0;
        end else if (ena) begin
            magnitude <= sat_next; // Holds while ena is low
        end
    end

endmodule

// File: tt_um_addon.sv
`timescale 1ns/100ps

module tt_um_addon (
    input  logic [7:0] ui_in,   // Operand x
    input  logic [7:0] uio_in,  // Operand y
    output logic [7:0] uo_out,  // Saturated magnitude
    output logic [7:0] uio_out, // Bidir output path, unused
    output logic [7:0] uio_oe,  // Bidir enables, all input
    input  logic       clk,     // Tile clock
    input  logic       rst_n,   // Async reset, active low
    input  logic       ena      // Level strobe, advances the pipeline
);

    import hyp_pkg::*;

    square_t square_x; // Stage 1 to stage 2
    square_t square_y;
    sumsq_t  sum_sq;   // Stage 2 to root pipe

    // Stage 1, squares
    hyp_square_stage u_square (
        .clk      (clk),
        .rst_n    (rst_n),
        .ena      (ena),
        .x        (ui_in),
        .y        (uio_in),
        .square_x (square_x),
        .square_y (square_y)
    );

    // Stage 2, full-width sum
    hyp_sum_stage u_sum (
        .clk      (clk),
        .rst_n    (rst_n),
        .ena      (ena),
        .square_x (square_x),
        .square_y (square_y),
        .sum_sq   (sum_sq)
    );

    // Stages 3 to 12, root steps plus saturating output
    hyp_root_pipe u_root (
        .clk       (clk),
        .rst_n     (rst_n),
        .ena       (ena),
        .sum_sq    (sum_sq),
        .magnitude (uo_out)
    );

    // Bidir pins unused by this tile
    assign uio_out = 8'h00;
    assign uio_oe  = 8'h00; // All pins left as inputs

endmodule

// File: hyp_checker.sv
`timescale 1ns/100ps

module hyp_checker (
    input  logic       clk,         // Tile clock
    input  logic       rst_n,       // DUT reset, watched only
    input  logic       ena,         // DUT advance strobe
    input  logic [7:0] ui_in,       // Operand x as driven
    input  logic [7:0] uio_in,      // Operand y as driven
    input  logic [7:0] uo_out,      // Magnitude under test
    input  logic [7:0] uio_out,     // Must stay zero
    input  logic [7:0] uio_oe,      // Must stay zero
    input  int         test_id,     // Current test number
    input  logic       test_done,   // One-cycle pulse at the end of a test
    input  logic       all_done,    // Request for the closing count line
    output int         error_count, // All errors so far
    output int         check_count  // All checks so far
);

    import hyp_pkg::*;

    localparam int PIPE_DEPTH = 12; // Enabled edges from input to uo_out

    pix_t       exp_q[$];     // Results still inside the pipeline
    pix_t       last_out;     // Expected uo_out after the last enabled edge
    pix_t       exp_val;      // Entry popped on this edge
    logic       edge_en;      // Last rising edge was enabled and out of reset
    logic [7:0] edge_x;       // Operands the DUT saw on that edge
    logic [7:0] edge_y;
    int         test_errors;  // Errors within the current test
    int         test_checks;  // Checks within the current test
    int         tests_ok;
    int         tests_bad;
    logic       summary_done; // Closing line printed once

    // Floor root by integer search, then clamp to one byte
    function automatic pix_t expected_mag(input logic [7:0] a, input logic [7:0] b);
        int sumsq;
        int root;
        sumsq = int'(a) * int'(a) + int'(b) * int'(b); // Up to 130050, no truncation
        root  = 0;
        while ((root + 1) * (root + 1) <= sumsq) begin
            root++;
        end
        if (root > 255) begin
            return 8'hff; // Saturate
        end
        return pix_t'(root);
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset";
            2:       return "directed corners";
            3:       return "streaming";
            4:       return "stall";
            default: return "unknown";
        endcase
    endfunction

    // One compare, counted in both totals
    task automatic check_byte(input string name, input logic [7:0] want,
                              input logic [7:0] got);
        check_count++;
        test_checks++;
        if (got !== want) begin // X or Z counts as wrong
            $display("** Error: %s expected %02h, got %02h at %0t", name, want, got, $time);
            error_count++;
            test_errors++;
        end
    endtask

    // Corner values known by hand
    task automatic check_reference(input logic [7:0] a, input logic [7:0] b,
                                   input logic [7:0] want);
        pix_t got;
        got = expected_mag(a, b);
        if (got !== want) begin
            $display("** Error: expected_mag(%02h, %02h) expected %02h, got %02h",
                     a, b, want, got);
            error_count++;
        end
    endtask

    task automatic report_test;
        if (test_errors == 0) begin
            tests_ok++;
            $display("test %0d %s: ok, %0d checks", test_id, test_name(test_id), test_checks);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors in %0d checks",
                     test_id, test_name(test_id), test_errors, test_checks);
        end
        test_errors = 0; // Fresh counts for the next test
        test_checks = 0;
    endtask

    initial begin
        error_count  = 0;
        check_count  = 0;
        test_errors  = 0;
        test_checks  = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        summary_done = 1'b0;
        edge_en      = 1'b0;
        last_out     = '0;
        // Table of the directed test
        check_reference(8'd0,   8'd0,   8'd0);
        check_reference(8'd3,   8'd4,   8'd5);
        check_reference(8'd255, 8'd0,   8'd255);
        check_reference(8'd0,   8'd1,   8'd1);
        check_reference(8'd180, 8'd180, 8'd254);
        check_reference(8'd181, 8'd181, 8'd255); // 255.97 floors to 255
        check_reference(8'd255, 8'd255, 8'd255); // 360 clamps
    end

    // What the DUT sampled on this edge; NBA keeps the pre-edge values
    always @(posedge clk) begin
        edge_en <= ena && rst_n; // Reset wins over ena
        edge_x  <= ui_in;
        edge_y  <= uio_in;
    end

    // Compare at the falling edge, all DUT outputs settled
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            repeat (PIPE_DEPTH - 1) exp_q.push_back('0); // Zeros already in flight
            last_out = '0;
            check_byte("uo_out", 8'h00, uo_out); // Cleared by reset
        end else if (edge_en) begin
            exp_q.push_back(expected_mag(edge_x, edge_y));
            exp_val = exp_q.pop_front(); // Pair from 12 enabled edges ago
            check_byte("uo_out", exp_val, uo_out);
            last_out = exp_val;
        end else begin
            check_byte("uo_out", last_out, uo_out); // Frozen while ena low
        end
        check_byte("uio_out", 8'h00, uio_out); // Tie-offs, every cycle
        check_byte("uio_oe", 8'h00, uio_oe);
        if (test_done) begin
            report_test();
        end
        if (all_done && !summary_done) begin
            summary_done = 1'b1;
            $display("summary: %0d tests ok, %0d tests with errors, %0d checks, %0d errors",
                     tests_ok, tests_bad, check_count, error_count);
        end
    end

endmodule

// File: tb_hypot.sv
`timescale 1ns/100ps

module tb_hypot;

    localparam int PIPE_DEPTH   = 12;  // Enabled edges from ui_in to uo_out
    localparam int RESET_CYCLES = 16;
    localparam int STREAM_PAIRS = 300;
    localparam int STALL_PAIRS  = 300;
    localparam int NUM_TESTS    = 4;
    localparam int LEN_RESET    = RESET_CYCLES + PIPE_DEPTH;
    localparam int LEN_DIRECTED = 7;
    localparam int LEN_STREAM   = STREAM_PAIRS;
    localparam int LEN_STALL    = 2 * STALL_PAIRS; // ena high about half the time
    localparam int TIMEOUT_CYCLES = 2 * (LEN_RESET + LEN_DIRECTED + LEN_STREAM
                                         + LEN_STALL + NUM_TESTS * PIPE_DEPTH);

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    int         test_id;     // Test number seen by the checker
    logic       test_done;   // End-of-test pulse
    logic       all_done;    // Ask for the closing line
    int         error_count; // From the checker
    int         check_count;
    int         cycle_count = 0;
    integer     seed;

    initial clk = 1'b0;
    always #20 clk = ~clk; // 40 ns period

    tt_um_addon tt_um_addon_i (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .clk     (clk),
        .rst_n   (rst_n),
        .ena     (ena)
    );

    hyp_checker hyp_checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ena         (ena),
        .ui_in       (ui_in),
        .uio_in      (uio_in),
        .uo_out      (uo_out),
        .uio_out     (uio_out),
        .uio_oe      (uio_oe),
        .test_id     (test_id),
        .test_done   (test_done),
        .all_done    (all_done),
        .error_count (error_count),
        .check_count (check_count)
    );

    task automatic send_pair(input logic [7:0] a, input logic [7:0] b);
        @(posedge clk);
        ui_in  <= a;
        uio_in <= b;
        ena    <= 1'b1;
    endtask

    task automatic send_random;
        logic [31:0] r;
        @(posedge clk);
        r = $random(seed);
        ui_in  <= r[7:0];
        uio_in <= r[15:8];
        ena    <= 1'b1;
    endtask

    // Random ena with only the taken pairs counted
    task automatic stall_pairs(input int count);
        logic [31:0] r;
        int          n;
        n = 0;
        while (n < count) begin
            @(posedge clk);
            r = $random(seed);
            ui_in  <= r[7:0]; // Changes even when ignored
            uio_in <= r[15:8];
            ena    <= r[16];
            if (r[16]) begin
                n++;
            end
        end
    endtask

    task automatic start_test(input int id);
        @(posedge clk);
        ena     <= 1'b0;
        test_id <= id;
    endtask

    // Push the last real pair out and then tell the checker
    task automatic end_test;
        repeat (PIPE_DEPTH) send_pair(8'h00, 8'h00);
        @(posedge clk);
        ena       <= 1'b0;
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    initial begin
        rst_n     = 1'b0;
        ena       = 1'b0;
        ui_in     = 8'h00;
        uio_in    = 8'h00;
        test_id   = 0;
        test_done = 1'b0;
        all_done  = 1'b0;
        seed      = 32'h551b_c92b;

        // Reset must win over ena and operands
        start_test(1);
        repeat (RESET_CYCLES - 2) send_random(); // Start and release edges make up the rest
        @(posedge clk);
        rst_n <= 1'b1;
        ena   <= 1'b0;
        repeat (PIPE_DEPTH) send_random(); // Reset zeros drain first
        end_test();

        start_test(2);
        send_pair(8'd0,   8'd0);
        send_pair(8'd3,   8'd4);
        send_pair(8'd255, 8'd0);
        send_pair(8'd0,   8'd1);
        send_pair(8'd180, 8'd180);
        send_pair(8'd181, 8'd181);
        send_pair(8'd255, 8'd255);
        end_test();

        start_test(3);
        repeat (STREAM_PAIRS) send_random(); // Back to back with ena high
        end_test();

        start_test(4);
        stall_pairs(STALL_PAIRS);
        end_test();

        @(posedge clk);
        all_done <= 1'b1;
        @(negedge clk);
        #1; // Checker has printed its counts
        if (error_count == 0 && check_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Hard stop if the stimulus never finishes
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without reaching the end",
                     cycle_count);
            $display("test failed");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+.
hyp_pkg.sv
hyp_square_stage.sv
hyp_sum_stage.sv
hyp_root_step.sv
hyp_root_pipe.sv
tt_um_addon.sv
hyp_checker.sv
tb_hypot.sv
